/* common/exec_macros.svh */
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// Data path width, RV32
`define XLEN 32

// Architectural register number
`define REG_IDX_W 5

// CSR address and CSR immediate widths
`define CSR_IDX_W 12
`define CSR_ZIMM_W 5

// Shift amount taken from operand b
`define SHAMT_W 5

`endif

/* common/exec_pkg.sv */
`default_nettype none

`include "exec_macros.svh"

package exec_pkg;

    // Plain vector types
    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`XLEN-1:0]       pc_t;
    typedef logic [`REG_IDX_W-1:0]  reg_idx_t;
    typedef logic [`CSR_ZIMM_W-1:0] csr_zimm_t;
    typedef logic [`CSR_IDX_W-1:0]  csr_idx_t;

    // Integer ALU operations
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    // Operand a select
    typedef enum logic [1:0] {
        ALU_OP1_SRC_RS1  = 2'd0,
        ALU_OP1_SRC_PC   = 2'd1,
        ALU_OP1_SRC_CSR  = 2'd2,
        ALU_OP1_SRC_ZERO = 2'd3
    } alu_op1_src_e;

    // Operand b select
    typedef enum logic [1:0] {
        ALU_OP2_SRC_RS1  = 2'd0,
        ALU_OP2_SRC_RS2  = 2'd1,
        ALU_OP2_SRC_IMM  = 2'd2,
        ALU_OP2_SRC_FOUR = 2'd3
    } alu_op2_src_e;

    // Conditional branch relations
    typedef enum logic [2:0] {
        CMP_EQ  = 3'd0,
        CMP_NE  = 3'd1,
        CMP_LT  = 3'd2,
        CMP_GE  = 3'd3,
        CMP_LTU = 3'd4,
        CMP_GEU = 3'd5
    } cmp_op_e;

    // Kind of control transfer
    typedef enum logic [1:0] {
        BRANCH_NONE = 2'd0,
        BRANCH_COND = 2'd1,
        BRANCH_JAL  = 2'd2,
        BRANCH_JALR = 2'd3
    } branch_type_e;

    // CSR operand from rs1 or the 5-bit immediate
    typedef enum logic {
        CSR_OP_SRC_RS1  = 1'b0,
        CSR_OP_SRC_ZIMM = 1'b1
    } csr_op_src_e;

    // CSRRW / CSRRS / CSRRC style update
    typedef enum logic [1:0] {
        CSR_ALU_OP_PASSTHRU = 2'd0,
        CSR_ALU_OP_BITSET   = 2'd1,
        CSR_ALU_OP_BITCLEAR = 2'd2
    } csr_alu_op_e;

    // Decoded instruction from D
    typedef struct packed {
        pc_t          pc;
        reg_idx_t     rs1_idx;
        reg_idx_t     rs2_idx;
        word_t        rs1_val;
        word_t        rs2_val;
        word_t        immediate;
        reg_idx_t     rd_idx;
        logic         rd_we;
        alu_op_e      alu_op;
        alu_op1_src_e alu_op1_src;
        alu_op2_src_e alu_op2_src;
        cmp_op_e      cmp_op;
        branch_type_e branch_type;
        csr_idx_t     csr_idx;
        word_t        csr_old_val;
        csr_zimm_t    csr_zimm;
        csr_op_src_e  csr_op_src;
        csr_alu_op_e  csr_alu_op;
        logic         csr_wen;
        logic [1:0]   mem_op;
    } d_to_e_s;

    // Result handed to M1
    typedef struct packed {
        pc_t        pc;
        reg_idx_t   rd_idx;
        logic       rd_we;
        logic       csr_wen;
        csr_idx_t   csr_idx;
        word_t      csr_new_val;
        word_t      alu_result;
        word_t      rs2_val;
        logic [1:0] mem_op;
        logic       branch_taken;
        pc_t        branch_target;
    } e_to_m1_s;

    // Bypass request from the stage
    typedef struct packed {
        logic     stage_uses_reg;
        reg_idx_t reg_idx;
    } fwd_req_s;

    // Bypass answer to the stage
    typedef struct packed {
        logic  use_fwd;
        word_t fwd_val;
    } fwd_rsp_s;

    // Result offered by a later stage
    typedef struct packed {
        logic     valid;
        logic     rd_we;
        reg_idx_t rd_idx;
        word_t    value;
    } fwd_src_s;

endpackage

`default_nettype wire

/* execute/exec_alu.sv */
`default_nettype none
`timescale 1ns/1ps

`include "exec_macros.svh"

module exec_alu (
    input  wire exec_pkg::word_t   operand_a,
    input  wire exec_pkg::word_t   operand_b,
    input  wire exec_pkg::alu_op_e operation,
    output exec_pkg::word_t        result
);

    logic [`SHAMT_W-1:0] shamt;

    // Shifts only look at the low bits of b
    assign shamt = operand_b[`SHAMT_W-1:0];

    always_comb begin
        case (operation)
            exec_pkg::ALU_ADD:  result = operand_a + operand_b;
            exec_pkg::ALU_SUB:  result = operand_a - operand_b;
            exec_pkg::ALU_SLL:  result = operand_a << shamt;
            // Set-less-than gives 0 or 1
            exec_pkg::ALU_SLT: begin
                result = exec_pkg::word_t'($signed(operand_a) < $signed(operand_b));
            end
            exec_pkg::ALU_SLTU: begin
                result = exec_pkg::word_t'(operand_a < operand_b);
            end
            exec_pkg::ALU_XOR:  result = operand_a ^ operand_b;
            exec_pkg::ALU_SRL:  result = operand_a >> shamt;
            // Arithmetic shift keeps the sign bit
            exec_pkg::ALU_SRA:  result = exec_pkg::word_t'($signed(operand_a) >>> shamt);
            exec_pkg::ALU_OR:   result = operand_a | operand_b;
            exec_pkg::ALU_AND:  result = operand_a & operand_b;
            default:            result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* execute/exec_branch_cmp.sv */
`default_nettype none
`timescale 1ns/1ps

module exec_branch_cmp (
    input  wire exec_pkg::word_t   rs1_val,
    input  wire exec_pkg::word_t   rs2_val,
    input  wire exec_pkg::cmp_op_e cmp_operation,
    output logic                   cmp_result
);

    always_comb begin
        case (cmp_operation)
            exec_pkg::CMP_EQ:  cmp_result = (rs1_val == rs2_val);
            exec_pkg::CMP_NE:  cmp_result = (rs1_val != rs2_val);
            // BLT and BGE are signed
            exec_pkg::CMP_LT:  cmp_result = ($signed(rs1_val) < $signed(rs2_val));
            exec_pkg::CMP_GE:  cmp_result = ($signed(rs1_val) >= $signed(rs2_val));
            // Unsigned variants
            exec_pkg::CMP_LTU: cmp_result = (rs1_val < rs2_val);
            exec_pkg::CMP_GEU: cmp_result = (rs1_val >= rs2_val);
            default:           cmp_result = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* execute/exec_stage.sv */
`default_nettype none
`timescale 1ns/1ps

module exec_stage (
    input  wire logic              clk,
    input  wire logic              rst_n,

    // Hazard control
    input  wire logic              flush,
    input  wire logic              stall,

    // From D
    input  wire logic              d_to_e_valid,
    input  wire exec_pkg::d_to_e_s d_to_e,

    // Bypass requests and answers
    output exec_pkg::fwd_req_s     fwd_req_rs1,
    output exec_pkg::fwd_req_s     fwd_req_rs2,
    input  wire exec_pkg::fwd_rsp_s fwd_rsp_rs1,
    input  wire exec_pkg::fwd_rsp_s fwd_rsp_rs2,

    // To M1
    output logic                   e_to_m1_valid,
    output exec_pkg::e_to_m1_s     e_to_m1
);

    logic              ff_in_valid;
    exec_pkg::d_to_e_s ff_in;

    exec_pkg::word_t   rs1_val;
    exec_pkg::word_t   rs2_val;
    exec_pkg::word_t   alu_operand_a;
    exec_pkg::word_t   alu_operand_b;
    exec_pkg::word_t   alu_result;
    logic              cmp_result;
    logic              branch_taken;
    exec_pkg::pc_t     branch_target;
    exec_pkg::word_t   csr_operand;
    exec_pkg::word_t   csr_new_val;

    // Only the valid bit is reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ff_in_valid <= 1'b0;
        end else if (!stall) begin
            ff_in_valid <= d_to_e_valid;
        end
    end

    // Instruction register holds under stall
    always_ff @(posedge clk) begin
        if (!stall) begin
            ff_in <= d_to_e;
        end
    end

    // Ask for bypasses of both source registers
    assign fwd_req_rs1.stage_uses_reg = ff_in_valid;
    assign fwd_req_rs1.reg_idx        = ff_in.rs1_idx;
    assign fwd_req_rs2.stage_uses_reg = ff_in_valid;
    assign fwd_req_rs2.reg_idx        = ff_in.rs2_idx;

    // Newer result replaces the decoded value
    assign rs1_val = fwd_rsp_rs1.use_fwd ? fwd_rsp_rs1.fwd_val : ff_in.rs1_val;
    assign rs2_val = fwd_rsp_rs2.use_fwd ? fwd_rsp_rs2.fwd_val : ff_in.rs2_val;

    // Operand a mux
    always_comb begin
        case (ff_in.alu_op1_src)
            exec_pkg::ALU_OP1_SRC_RS1: alu_operand_a = rs1_val;
            exec_pkg::ALU_OP1_SRC_PC:  alu_operand_a = ff_in.pc;
            exec_pkg::ALU_OP1_SRC_CSR: alu_operand_a = ff_in.csr_old_val;
            default:                   alu_operand_a = '0;
        endcase
    end

    // Operand b mux
    always_comb begin
        case (ff_in.alu_op2_src)
            exec_pkg::ALU_OP2_SRC_RS1: alu_operand_b = rs1_val;
            exec_pkg::ALU_OP2_SRC_RS2: alu_operand_b = rs2_val;
            exec_pkg::ALU_OP2_SRC_IMM: alu_operand_b = ff_in.immediate;
            default:                   alu_operand_b = exec_pkg::word_t'(4);
        endcase
    end

    exec_alu alu0 (
        .operand_a (alu_operand_a),
        .operand_b (alu_operand_b),
        .operation (ff_in.alu_op),
        .result    (alu_result)
    );

    // Comparator always sees the bypassed register values
    exec_branch_cmp cmp0 (
        .rs1_val       (rs1_val),
        .rs2_val       (rs2_val),
        .cmp_operation (ff_in.cmp_op),
        .cmp_result    (cmp_result)
    );

    // Jumps always taken, conditional ones by the comparator
    always_comb begin
        case (ff_in.branch_type)
            exec_pkg::BRANCH_COND: branch_taken = cmp_result;
            exec_pkg::BRANCH_JAL:  branch_taken = 1'b1;
            exec_pkg::BRANCH_JALR: branch_taken = 1'b1;
            default:               branch_taken = 1'b0;
        endcase
    end

    // JALR is register relative, the rest pc relative
    assign branch_target = (ff_in.branch_type == exec_pkg::BRANCH_JALR)
                         ? rs1_val + ff_in.immediate
                         : ff_in.pc + ff_in.immediate;

    // CSR operand, zimm zero extended
    assign csr_operand = (ff_in.csr_op_src == exec_pkg::CSR_OP_SRC_ZIMM)
                       ? exec_pkg::word_t'(ff_in.csr_zimm)
                       : rs1_val;

    // Write, set or clear bits of the old value
    always_comb begin
        case (ff_in.csr_alu_op)
            exec_pkg::CSR_ALU_OP_BITSET:   csr_new_val = ff_in.csr_old_val | csr_operand;
            exec_pkg::CSR_ALU_OP_BITCLEAR: csr_new_val = ff_in.csr_old_val & ~csr_operand;
            default:                       csr_new_val = csr_operand;
        endcase
    end

    // Nothing leaves while flushed or stalled
    assign e_to_m1_valid = ff_in_valid && !flush && !stall;

    always_comb begin
        e_to_m1.pc            = ff_in.pc;
        e_to_m1.rd_idx        = ff_in.rd_idx;
        e_to_m1.rd_we         = ff_in.rd_we;
        e_to_m1.csr_wen       = ff_in.csr_wen;
        e_to_m1.csr_idx       = ff_in.csr_idx;
        e_to_m1.csr_new_val   = csr_new_val;
        e_to_m1.alu_result    = alu_result;
        // Store data needs the bypassed value too
        e_to_m1.rs2_val       = rs2_val;
        e_to_m1.mem_op        = ff_in.mem_op;
        e_to_m1.branch_taken  = branch_taken;
        e_to_m1.branch_target = branch_target;
    end

endmodule

`default_nettype wire

/* verilog/exec_forward_unit.sv */
`default_nettype none
`timescale 1ns/1ps

module exec_forward_unit (
    input  wire exec_pkg::fwd_req_s fwd_req_rs1,
    input  wire exec_pkg::fwd_req_s fwd_req_rs2,
    input  wire exec_pkg::fwd_src_s m1_src,
    input  wire exec_pkg::fwd_src_s m2_src,
    output exec_pkg::fwd_rsp_s      fwd_rsp_rs1,
    output exec_pkg::fwd_rsp_s      fwd_rsp_rs2
);

    // True when a later stage writes the requested register
    function automatic logic src_match(
        input exec_pkg::fwd_src_s src,
        input exec_pkg::reg_idx_t idx
    );
        src_match = src.valid && src.rd_we && (src.rd_idx == idx) && (idx != '0);
    endfunction

    // M1 holds the younger result, so it is checked first
    function automatic exec_pkg::fwd_rsp_s pick(
        input exec_pkg::fwd_req_s req,
        input exec_pkg::fwd_src_s m1,
        input exec_pkg::fwd_src_s m2
    );
        exec_pkg::fwd_rsp_s rsp;
        logic               m1_hit;
        logic               m2_hit;
        m1_hit      = src_match(m1, req.reg_idx);
        m2_hit      = src_match(m2, req.reg_idx);
        rsp.use_fwd = req.stage_uses_reg && (m1_hit || m2_hit);
        rsp.fwd_val = m1_hit ? m1.value : m2.value;
        pick        = rsp;
    endfunction

    // Same selection for both source operands
    always_comb begin
        fwd_rsp_rs1 = pick(fwd_req_rs1, m1_src, m2_src);
        fwd_rsp_rs2 = pick(fwd_req_rs2, m1_src, m2_src);
    end

endmodule

`default_nettype wire

/* verilog/exec_top.sv */
`default_nettype none
`timescale 1ns/1ps

module exec_top (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               flush,
    input  wire logic               stall,
    input  wire logic               d_to_e_valid,
    input  wire exec_pkg::d_to_e_s  d_to_e,
    input  wire exec_pkg::fwd_src_s m1_src,
    input  wire exec_pkg::fwd_src_s m2_src,
    output logic                    e_to_m1_valid,
    output exec_pkg::e_to_m1_s      e_to_m1
);

    // Bypass handshake between stage and forwarding unit
    exec_pkg::fwd_req_s fwd_req_rs1;
    exec_pkg::fwd_req_s fwd_req_rs2;
    exec_pkg::fwd_rsp_s fwd_rsp_rs1;
    exec_pkg::fwd_rsp_s fwd_rsp_rs2;

    exec_stage stage0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .stall         (stall),
        .d_to_e_valid  (d_to_e_valid),
        .d_to_e        (d_to_e),
        .fwd_req_rs1   (fwd_req_rs1),
        .fwd_req_rs2   (fwd_req_rs2),
        .fwd_rsp_rs1   (fwd_rsp_rs1),
        .fwd_rsp_rs2   (fwd_rsp_rs2),
        .e_to_m1_valid (e_to_m1_valid),
        .e_to_m1       (e_to_m1)
    );

    exec_forward_unit fwd0 (
        .fwd_req_rs1 (fwd_req_rs1),
        .fwd_req_rs2 (fwd_req_rs2),
        .m1_src      (m1_src),
        .m2_src      (m2_src),
        .fwd_rsp_rs1 (fwd_rsp_rs1),
        .fwd_rsp_rs2 (fwd_rsp_rs2)
    );

endmodule

`default_nettype wire

/* test/tb_exec_top.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_exec_top;

    localparam int CLK_PERIOD = 10;
    localparam int VEC_WORDS  = 20;
    localparam int MAX_VECS   = 64;
    localparam int RAND_COUNT = 20;

    logic               clk;
    logic               rst_n;
    logic               flush;
    logic               stall;
    logic               d_to_e_valid;
    exec_pkg::d_to_e_s  d_to_e;
    exec_pkg::fwd_src_s m1_src;
    exec_pkg::fwd_src_s m2_src;
    logic               e_to_m1_valid;
    exec_pkg::e_to_m1_s e_to_m1;

    // One vector is VEC_WORDS consecutive words, one line of the file
    logic [31:0] vec_mem [0:MAX_VECS*VEC_WORDS-1];
    int          num_vecs;
    logic        vecs_loaded;
    int          error_count;
    int          seed;

    // Instruction and valid the stage register holds in the check cycle
    exec_pkg::d_to_e_s held_instr;
    logic              held_valid;

    exec_top dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .stall         (stall),
        .d_to_e_valid  (d_to_e_valid),
        .d_to_e        (d_to_e),
        .m1_src        (m1_src),
        .m2_src        (m2_src),
        .e_to_m1_valid (e_to_m1_valid),
        .e_to_m1       (e_to_m1)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s expected 0x%h actual 0x%h", name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Register value after bypass, newest writer first, x0 never bypassed
    function automatic logic [31:0] bypassed_value(
        input logic in_use, input logic [4:0] idx, input logic [31:0] decoded,
        input exec_pkg::fwd_src_s m1, input exec_pkg::fwd_src_s m2
    );
        if (!in_use || idx == 5'd0) begin
            return decoded;
        end
        if (m1.valid && m1.rd_we && m1.rd_idx == idx) begin
            return m1.value;
        end
        if (m2.valid && m2.rd_we && m2.rd_idx == idx) begin
            return m2.value;
        end
        return decoded;
    endfunction

    // Builds a decoded instruction from the packed op and CSR words
    function automatic exec_pkg::d_to_e_s make_instr(
        input logic [31:0] pc, input logic [31:0] rs1_idx, input logic [31:0] rs2_idx,
        input logic [31:0] rs1_val, input logic [31:0] rs2_val, input logic [31:0] imm,
        input logic [31:0] ops, input logic [31:0] csr, input logic [31:0] csr_old,
        input logic [31:0] zimm
    );
        exec_pkg::d_to_e_s instr;
        instr             = '0;
        instr.pc          = pc;
        instr.rs1_idx     = rs1_idx[4:0];
        instr.rs2_idx     = rs2_idx[4:0];
        instr.rs1_val     = rs1_val;
        instr.rs2_val     = rs2_val;
        instr.immediate   = imm;
        instr.rd_idx      = 5'd3;
        instr.rd_we       = 1'b1;
        instr.alu_op      = exec_pkg::alu_op_e'(ops[19:16]);
        instr.alu_op1_src = exec_pkg::alu_op1_src_e'(ops[13:12]);
        instr.alu_op2_src = exec_pkg::alu_op2_src_e'(ops[9:8]);
        instr.cmp_op      = exec_pkg::cmp_op_e'(ops[6:4]);
        instr.branch_type = exec_pkg::branch_type_e'(ops[1:0]);
        instr.csr_idx     = 12'h300;
        instr.csr_old_val = csr_old;
        instr.csr_zimm    = zimm[4:0];
        instr.csr_op_src  = exec_pkg::csr_op_src_e'(csr[4]);
        instr.csr_alu_op  = exec_pkg::csr_alu_op_e'(csr[1:0]);
        instr.csr_wen     = 1'b0;
        instr.mem_op      = 2'b00;
        return instr;
    endfunction

    // Control word holds valid at bit 12, rd_we at bit 8, rd_idx below
    function automatic exec_pkg::fwd_src_s make_src(input logic [31:0] ctrl,
                                                    input logic [31:0] value);
        exec_pkg::fwd_src_s src;
        src.valid  = ctrl[12];
        src.rd_we  = ctrl[8];
        src.rd_idx = ctrl[4:0];
        src.value  = value;
        return src;
    endfunction

    // Accept on one edge, then check the result in the following cycle
    task automatic run_vector(
        input logic [31:0] ctrl, input exec_pkg::d_to_e_s instr,
        input exec_pkg::fwd_src_s m1, input exec_pkg::fwd_src_s m2,
        input logic [31:0] exp_valid, input logic [31:0] exp_alu,
        input logic [31:0] exp_taken, input logic [31:0] exp_target,
        input logic [31:0] exp_csr
    );
        @(negedge clk);
        d_to_e_valid = ctrl[0];
        stall        = ctrl[4];
        flush        = 1'b0;
        d_to_e       = instr;
        m1_src       = '0;
        m2_src       = '0;
        // Stage register loads at the coming edge unless stalled
        if (!ctrl[4]) begin
            held_instr = instr;
            held_valid = ctrl[0];
        end
        @(negedge clk);
        d_to_e_valid = 1'b0;
        stall        = ctrl[8];
        flush        = ctrl[12];
        m1_src       = m1;
        m2_src       = m2;
        // Quarter period in, well clear of both edges
        #(CLK_PERIOD/4);
        check_value("e_to_m1_valid", exp_valid, 32'(e_to_m1_valid));
        check_value("alu_result", exp_alu, e_to_m1.alu_result);
        check_value("branch_taken", exp_taken, 32'(e_to_m1.branch_taken));
        check_value("branch_target", exp_target, e_to_m1.branch_target);
        check_value("csr_new_val", exp_csr, e_to_m1.csr_new_val);
        // Fields that pass straight through from the held instruction
        check_value("pc", held_instr.pc, e_to_m1.pc);
        check_value("rd_idx", 32'(held_instr.rd_idx), 32'(e_to_m1.rd_idx));
        check_value("rd_we", 32'(held_instr.rd_we), 32'(e_to_m1.rd_we));
        check_value("csr_wen", 32'(held_instr.csr_wen), 32'(e_to_m1.csr_wen));
        check_value("csr_idx", 32'(held_instr.csr_idx), 32'(e_to_m1.csr_idx));
        check_value("mem_op", 32'(held_instr.mem_op), 32'(e_to_m1.mem_op));
        // Store data is the bypassed rs2
        check_value("rs2_val",
                    bypassed_value(held_valid, held_instr.rs2_idx, held_instr.rs2_val,
                                   m1, m2),
                    e_to_m1.rs2_val);
        // Edge after the check reloads the same instruction with valid low
        if (!ctrl[8]) begin
            held_instr = instr;
            held_valid = 1'b0;
        end
    endtask

    initial begin
        int                base;
        logic [31:0]       op_a;
        logic [31:0]       op_b;
        logic [31:0]       rnd;
        logic [31:0]       exp_res;
        exec_pkg::d_to_e_s instr;
        clk          = 1'b0;
        rst_n        = 1'b0;
        flush        = 1'b0;
        stall        = 1'b0;
        // Valid input during reset must not get through
        d_to_e_valid = 1'b1;
        d_to_e       = '0;
        m1_src       = '0;
        m2_src       = '0;
        held_instr   = '0;
        held_valid   = 1'b0;
        error_count  = 0;
        seed         = 96623;
        vecs_loaded  = 1'b0;
        num_vecs     = 0;
        // Unused slots hold an address based pattern that marks the end of the list
        for (int i = 0; i < MAX_VECS*VEC_WORDS; i++) begin
            vec_mem[i] = 32'hdead_0000 ^ 32'(i);
        end
        $readmemh("test/exec_tests.mem", vec_mem);
        while (num_vecs < MAX_VECS &&
               vec_mem[num_vecs*VEC_WORDS] != (32'hdead_0000 ^ 32'(num_vecs*VEC_WORDS))) begin
            num_vecs++;
        end
        vecs_loaded = 1'b1;

        // Output stays quiet through reset and just after it
        repeat (5) begin
            @(negedge clk);
            check_value("e_to_m1_valid", 32'h0, 32'(e_to_m1_valid));
        end
        rst_n        = 1'b1;
        d_to_e_valid = 1'b0;
        @(negedge clk);
        check_value("e_to_m1_valid", 32'h0, 32'(e_to_m1_valid));

        for (int v = 0; v < num_vecs; v++) begin
            base  = v * VEC_WORDS;
            instr = make_instr(vec_mem[base+1], vec_mem[base+2], vec_mem[base+3],
                               vec_mem[base+4], vec_mem[base+5], vec_mem[base+6],
                               vec_mem[base+7], vec_mem[base+8], vec_mem[base+9],
                               vec_mem[base+10]);
            // Pass-through fields change from vector to vector
            instr.rd_idx  = 5'(v + 1);
            instr.rd_we   = v[0];
            instr.csr_wen = v[1];
            instr.csr_idx = 12'(32'h300 + v);
            instr.mem_op  = 2'(v);
            run_vector(vec_mem[base], instr,
                       make_src(vec_mem[base+11], vec_mem[base+12]),
                       make_src(vec_mem[base+13], vec_mem[base+14]),
                       vec_mem[base+15], vec_mem[base+16], vec_mem[base+17],
                       vec_mem[base+18], vec_mem[base+19]);
        end

        // Random ADD and XOR, no bypass
        for (int r = 0; r < RAND_COUNT; r++) begin
            op_a    = $random(seed);
            op_b    = $random(seed);
            rnd     = $random(seed);
            exp_res = rnd[0] ? (op_a ^ op_b) : (op_a + op_b);
            instr   = make_instr(32'h100, 32'd1, 32'd2, op_a, op_b, 32'h8,
                                 rnd[0] ? 32'h50100 : 32'h00100, 32'h0, 32'h0, 32'h0);
            run_vector(32'h1, instr, '0, '0, 32'h1, exp_res, 32'h0, 32'h108, op_a);
        end

        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Each vector needs two cycles, so four per vector leaves margin
    initial begin
        wait (vecs_loaded);
        #((num_vecs + RAND_COUNT + 20) * 4 * CLK_PERIOD);
        $display("Timeout: the test sequence did not finish in time");
        $display("STATUS: FAIL");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

/* test/exec_tests.mem */
// ctrl pc rs1_idx rs2_idx rs1 rs2 imm ops csr csr_old zimm m1_ctrl m1_val m2_ctrl m2_val
// exp_valid exp_alu exp_taken exp_target exp_csr (ops = alu op1 op2 cmp br nibbles)
1 100 1 2 5 7 8 00100 0 0 0 0 0 0 0 1 c 0 108 5
1 100 1 2 5 7 8 10100 0 0 0 0 0 0 0 1 fffffffe 0 108 5
1 100 1 2 3 24 8 20100 0 0 0 0 0 0 0 1 30 0 108 3
1 100 1 2 ffffffff 1 8 30100 0 0 0 0 0 0 0 1 1 0 108 ffffffff
1 100 1 2 ffffffff 1 8 40100 0 0 0 0 0 0 0 1 0 0 108 ffffffff
1 100 1 2 f0f0 0 ff 50200 0 0 0 0 0 0 0 1 f00f 0 1ff f0f0
1 100 1 2 80000000 4 8 60100 0 0 0 0 0 0 0 1 8000000 0 108 80000000
1 100 1 2 80000000 4 8 70100 0 0 0 0 0 0 0 1 f8000000 0 108 80000000
1 100 1 2 0 0 23 81200 0 0 0 0 0 0 0 1 123 0 123 0
1 100 1 2 0 ff0 8 92100 0 ff00ff00 0 0 0 0 0 1 f00 0 108 0
1 100 1 2 9 0 8 03300 0 0 0 0 0 0 0 1 4 0 108 9
1 100 1 2 6 0 8 00000 0 0 0 0 0 0 0 1 c 0 108 6
1 100 1 2 5 5 40 00101 0 0 0 0 0 0 0 1 a 1 140 5
1 100 1 2 3 5 40 00101 0 0 0 0 0 0 0 1 8 0 140 3
1 100 1 2 7 5 40 00101 0 0 0 0 0 0 0 1 c 0 140 7
1 100 1 2 5 5 40 00111 0 0 0 0 0 0 0 1 a 0 140 5
1 100 1 2 3 5 40 00111 0 0 0 0 0 0 0 1 8 1 140 3
1 100 1 2 7 5 40 00111 0 0 0 0 0 0 0 1 c 1 140 7
1 100 1 2 5 5 40 00121 0 0 0 0 0 0 0 1 a 0 140 5
1 100 1 2 ffffffff 1 40 00121 0 0 0 0 0 0 0 1 0 1 140 ffffffff
1 100 1 2 1 ffffffff 40 00121 0 0 0 0 0 0 0 1 0 0 140 1
1 100 1 2 5 5 40 00131 0 0 0 0 0 0 0 1 a 1 140 5
1 100 1 2 ffffffff 1 40 00131 0 0 0 0 0 0 0 1 0 0 140 ffffffff
1 100 1 2 1 ffffffff 40 00131 0 0 0 0 0 0 0 1 0 1 140 1
1 100 1 2 5 5 40 00141 0 0 0 0 0 0 0 1 a 0 140 5
1 100 1 2 1 ffffffff 40 00141 0 0 0 0 0 0 0 1 0 1 140 1
1 100 1 2 ffffffff 1 40 00141 0 0 0 0 0 0 0 1 0 0 140 ffffffff
1 100 1 2 5 5 40 00151 0 0 0 0 0 0 0 1 a 1 140 5
1 100 1 2 1 ffffffff 40 00151 0 0 0 0 0 0 0 1 0 0 140 1
1 100 1 2 ffffffff 1 40 00151 0 0 0 0 0 0 0 1 0 1 140 ffffffff
1 100 1 2 0 0 40 01302 0 0 0 0 0 0 0 1 104 1 140 0
1 100 1 2 200 0 10 01303 0 0 0 0 0 0 0 1 104 1 210 200
1 100 1 2 5 5 40 00100 0 0 0 0 0 0 0 1 a 0 140 5
1 100 1 2 f 0 8 00100 0 f0 3 0 0 0 0 1 f 0 108 f
1 100 1 2 f 0 8 00100 10 f0 3 0 0 0 0 1 f 0 108 3
1 100 1 2 f 0 8 00100 1 f0 3 0 0 0 0 1 f 0 108 ff
1 100 1 2 f 0 8 00100 11 f0 3 0 0 0 0 1 f 0 108 f3
1 100 1 2 30 0 8 00100 2 f0 3 0 0 0 0 1 30 0 108 c0
1 100 1 2 30 0 8 00100 12 ff 3 0 0 0 0 1 30 0 108 fc
1 100 1 2 5 7 8 00100 0 0 0 1101 100 0 0 1 107 0 108 100
1 100 1 2 5 7 8 00100 0 0 0 0 0 1102 20 1 25 0 108 5
1 100 1 2 5 7 8 00100 0 0 0 1101 100 1101 300 1 107 0 108 100
1 100 1 2 5 7 8 00100 0 0 0 1102 10 1101 30 1 40 0 108 30
1 100 0 2 5 7 8 00100 0 0 0 1100 100 0 0 1 c 0 108 5
1 100 1 2 5 7 8 00100 0 0 0 1001 100 0 0 1 c 0 108 5
1 100 1 2 5 7 8 00100 0 0 0 0101 100 0 0 1 c 0 108 5
1 100 1 2 5 7 8 00100 0 0 0 1103 100 1101 50 1 57 0 108 50
1 100 1 2 0 0 10 01303 0 0 0 1101 400 0 0 1 104 1 410 400
101 100 1 2 11 22 8 00100 0 0 0 0 0 0 0 0 33 0 108 11
11 100 1 2 aa bb 8 10100 0 0 0 0 0 0 0 1 33 0 108 11
1001 100 1 2 1 2 8 00100 0 0 0 0 0 0 0 0 3 0 108 1
1 100 1 2 4 5 8 00100 0 0 0 0 0 0 0 1 9 0 108 4
0 100 1 2 1 1 8 00100 0 0 0 0 0 0 0 0 2 0 108 1

/* sim.f */
+incdir+common
common/exec_pkg.sv
execute/exec_alu.sv
execute/exec_branch_cmp.sv
execute/exec_stage.sv
verilog/exec_forward_unit.sv
verilog/exec_top.sv
test/tb_exec_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f sim.f --top-module tb_exec_top \
    --Mdir obj_dir -o tb_exec_top_sim

./obj_dir/tb_exec_top_sim | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
    echo "Simulation failed"
    exit 1
fi

echo "Simulation finished"
